/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ns -j 0
TOP      = coreTb
FILELIST = src.f
PASS     = TEST RESULT: PASS

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS)"

clean:
	rm -rf obj_dir

/* sim/coreChecker.sv */
`timescale 1ns/1ns

module coreChecker
    import isaPkg::*;
    import pipePkg::*;
(
    input logic clk,
    input logic rst,
    input logic takenBranch,
    input logic jump,
    input logic freeze,
    input wordT pc,
    input wordT exTarget,
    input memReqT dmemReq,
    input logic dmemReady,
    input retireT retire
);

    int failCount = 0;

    // A redirect that is not frozen must load its target into the pc on the next edge
    // A load-use hold in the same cycle would leave the old pc in place
    redirectTakesEffect: assert property (
        @(posedge clk) disable iff (rst)
            ((takenBranch || jump) && !freeze) |=> (pc == $past(exTarget))
    ) else begin
        $error("redirect did not load its target into the pc");
        failCount++;
    end

    // Memory may take its time, but the request it is looking at must not move
    requestHeld: assert property (
        @(posedge clk) disable iff (rst) (dmemReq.valid && !dmemReady) |=> $stable(dmemReq)
    ) else begin
        $error("data memory request changed while waiting for ready");
        failCount++;
    end

    // Each reset edge leaves the pipeline empty
    quietAfterReset: assert property (
        @(posedge clk) rst |=> (!retire.valid && !dmemReq.valid)
    ) else begin
        $error("retire or memory request valid right after a reset cycle");
        failCount++;
    end

endmodule

/* sim/coreTb.sv */
`timescale 1ns/1ns
`include "coreCfg.svh"

module coreTb
    import isaPkg::*;
    import pipePkg::*;
();

    localparam int memWords = 256;
    localparam int modelStepLimit = 1000;

    logic clk = 1'b0;
    logic rst;
    wordT imemAddr;
    wordT imemData;
    memReqT dmemReq;
    wordT dmemRdata;
    logic dmemReady;
    retireT retire;

    wordT imem [0:memWords-1];
    wordT dmem [0:memWords-1];
    wordT modelMem [0:memWords-1];
    retireT expected [$];
    int expectedCount = 0;
    int retiredCount = 0;
    int cycleCount = 0;
    int cycleLimit = 1000;
    int retireErrors = 0;
    int memErrors = 0;
    int resetErrors = 0;
    int assertFails;
    logic [31:0] lfsrState = 32'hcd87_6082;
    logic [1:0] readyBits;

    always #10 clk = ~clk;

    pipelineCore pipelineCore_i (
        .clk(clk),
        .rst(rst),
        .imemAddr(imemAddr),
        .imemData(imemData),
        .dmemReq(dmemReq),
        .dmemRdata(dmemRdata),
        .dmemReady(dmemReady),
        .retire(retire)
    );

    bind pipelineCore coreChecker coreChecker_i (
        .clk(clk),
        .rst(rst),
        .takenBranch(takenBranch),
        .jump(jump),
        .freeze(freeze),
        .pc(pc),
        .exTarget(exTarget),
        .dmemReq(dmemReq),
        .dmemReady(dmemReady),
        .retire(retire)
    );

    // Both memories answer in the same cycle
    assign imemData = imem[imemAddr[9:2]];
    assign dmemRdata = dmem[dmemReq.addr[9:2]];

    // A store is taken in the cycle ready is high, while the request is steady
    always @(negedge clk) begin
        if (!rst && dmemReq.valid && dmemReq.write && dmemReady) begin
            dmem[dmemReq.addr[9:2]] = dmemReq.wdata;
        end
    end

    // Taps 32, 22, 2 and 1 give a maximal length sequence
    function automatic logic [31:0] lfsrStep(logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // Ready drops when both drawn bits are set, about one cycle in four
    always @(posedge clk) begin
        #2;
        lfsrState = lfsrStep(lfsrState);
        readyBits[0] = lfsrState[0];
        lfsrState = lfsrStep(lfsrState);
        readyBits[1] = lfsrState[0];
        dmemReady = !(&readyBits);
    end

    // Instruction-set model over the same program and data image
    // Each supported instruction adds one expected retire record
    function automatic void runModel();
        wordT regs [0:31];
        wordT pc;
        wordT nextPc;
        wordT instr;
        wordT immI;
        wordT immS;
        wordT immB;
        wordT immJ;
        wordT a;
        wordT b;
        wordT addr;
        retireT rec;
        logic known;
        logic halted;
        int steps;
        foreach (regs[i]) begin
            regs[i] = '0;
        end
        pc = `RESET_PC;
        halted = 1'b0;
        steps = 0;
        while (!halted && steps < modelStepLimit) begin
            instr = imem[pc[9:2]];
            immI = {{20{instr[31]}}, instr[31:20]};
            immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            a = regs[instr[19:15]];
            b = regs[instr[24:20]];
            rec = '0;
            rec.valid = 1'b1;
            rec.pc = pc;
            rec.rd = instr[11:7];
            known = 1'b1;
            nextPc = pc + 32'd4;
            case (instr[6:0])
                7'b0110011: begin
                    rec.regWrite = 1'b1;
                    case ({instr[31:25], instr[14:12]})
                        10'b0000000_000: rec.result = a + b;
                        10'b0100000_000: rec.result = a - b;
                        10'b0000000_111: rec.result = a & b;
                        10'b0000000_110: rec.result = a | b;
                        10'b0000000_010: rec.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: known = 1'b0;
                    endcase
                end
                7'b0010011: begin
                    known = (instr[14:12] == 3'b000);
                    rec.regWrite = 1'b1;
                    rec.result = a + immI;
                end
                7'b0000011: begin
                    known = (instr[14:12] == 3'b010);
                    addr = a + immI;
                    rec.regWrite = 1'b1;
                    rec.result = modelMem[addr[9:2]];
                end
                7'b0100011: begin
                    known = (instr[14:12] == 3'b010);
                    addr = a + immS;
                    if (known) begin
                        modelMem[addr[9:2]] = b;
                    end
                end
                7'b1100011: begin
                    // BEQ is the only branch in the subset
                    known = (instr[14:12] == 3'b000);
                    if (known && (a == b)) begin
                        nextPc = pc + immB;
                    end
                end
                7'b1101111: begin
                    rec.regWrite = 1'b1;
                    rec.result = pc + 32'd4;
                    nextPc = pc + immJ;
                    // A jump to itself ends the program
                    halted = (immJ == '0);
                end
                default: known = 1'b0;
            endcase
            if (known) begin
                if (rec.regWrite && (rec.rd != '0)) begin
                    regs[rec.rd] = rec.result;
                end
                expected.push_back(rec);
            end
            pc = nextPc;
            steps++;
        end
    endfunction

    // rd and result only matter for instructions that write a register
    task automatic checkRetire(retireT actual, retireT want);
        logic mismatch;
        mismatch = (actual.pc != want.pc) || (actual.regWrite != want.regWrite);
        if (want.regWrite) begin
            mismatch = mismatch || (actual.rd != want.rd) || (actual.result != want.result);
        end
        if (mismatch) begin
            $display("Error at %0t ns: retired pc %h wr %b x%0d=%h, expected pc %h wr %b x%0d=%h",
                $time, actual.pc, actual.regWrite, actual.rd, actual.result,
                want.pc, want.regWrite, want.rd, want.result);
            retireErrors++;
        end
    endtask

    task automatic checkMemWord(int index, wordT actual, wordT want);
        if (actual != want) begin
            $display("Error at %0t ns: data word %0d is %h, expected %h",
                $time, index, actual, want);
            memErrors++;
        end
    endtask

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        if (rst) begin
            if (retire.valid || dmemReq.valid) begin
                $display("A retire or a memory request was active during reset at %0t ns", $time);
                resetErrors++;
            end
        end else if (retire.valid) begin
            if (expected.size() == 0) begin
                $display("An instruction at pc %h retired after the end of the program", retire.pc);
                retireErrors++;
            end else begin
                checkRetire(retire, expected.pop_front());
            end
            retiredCount++;
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout after %0d cycles with %0d of %0d instructions retired",
                cycleCount, retiredCount, expectedCount);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        dmemReady = 1'b1;
        for (int i = 0; i < memWords; i++) begin
            imem[i] = '0;
            // Every word differs, so a load from a wrong address shows up
            dmem[i] = 32'h5a00_0000 ^ (i * 32'h0001_0203);
            modelMem[i] = dmem[i];
        end
        $readmemh("sim/program.hex", imem);
        runModel();
        expectedCount = expected.size();
        cycleLimit = 8 * expectedCount + 50;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        while (retiredCount < expectedCount) begin
            @(posedge clk);
        end
        for (int i = 0; i < memWords; i++) begin
            checkMemWord(i, dmem[i], modelMem[i]);
        end
        assertFails = pipelineCore_i.coreChecker_i.failCount;
        $display("Summary: %0d retire errors, %0d memory errors, %0d reset errors, %0d assertion fails",
            retireErrors, memErrors, resetErrors, assertFails);
        if (retireErrors + memErrors + resetErrors + assertFails == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* sim/program.hex */
// One instruction word per line from address 0
// The comment gives the word address and the assembly
00500093 // 00 addi x1, x0, 5
00308113 // 04 addi x2, x1, 3
002081B3 // 08 add  x3, x1, x2
40118233 // 0c sub  x4, x3, x1
00700013 // 10 addi x0, x0, 7
004002B3 // 14 add  x5, x0, x4
00322333 // 18 slt  x6, x4, x3
00302823 // 1c sw   x3, 16(x0)
01002383 // 20 lw   x7, 16(x0)
00638433 // 24 add  x8, x7, x6
003474B3 // 28 and  x9, x8, x3
0014E533 // 2c or   x10, x9, x1
02802583 // 30 lw   x11, 40(x0)
00B02A23 // 34 sw   x11, 20(x0)
00350663 // 38 beq  x10, x3, +12
00100613 // 3c addi x12, x0, 1
00200613 // 40 addi x12, x0, 2
00208463 // 44 beq  x1, x2, +8
00C006EF // 48 jal  x13, +12
00300713 // 4c addi x14, x0, 3
00400713 // 50 addi x14, x0, 4
00D02C23 // 54 sw   x13, 24(x0)
0000006F // 58 jal  x0, 0

/* source/coreCfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Width of data words, addresses and register values
`define XLEN 32

// Number of bits in a register number
`define REG_AW 5

// Address of the first instruction fetched after reset
`define RESET_PC 32'h0000_0000

`endif

/* source/decoder.sv */
`timescale 1ns/1ns

module decoder
    import isaPkg::*;
    import pipePkg::*;
(
    input wordT pc,
    input wordT instr,
    output executeStageT fields
);

    logic [2:0] funct3;
    logic [6:0] funct7;
    immKindT immKind;
    logic supported;

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // Sign-extended immediate for each instruction format
    function automatic wordT immediate(wordT word, immKindT kind);
        case (kind)
            immS: return {{20{word[31]}}, word[31:25], word[11:7]};
            immB: return {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
            immJ: return {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
            default: return {{20{word[31]}}, word[31:20]};
        endcase
    endfunction

    always_comb begin
        fields = '0;
        fields.pc = pc;
        fields.rs1 = instr[19:15];
        fields.rs2 = instr[24:20];
        fields.rd = instr[11:7];
        fields.aluOp = aluAdd;
        immKind = immI;
        supported = 1'b0;

        // Unused source fields are zeroed so they never cause a false stall
        case (opcodeT'(instr[6:0]))
            OP: begin
                supported = 1'b1;
                fields.regWrite = 1'b1;
                case ({funct7, funct3})
                    {funct7Base, funct3Add}: fields.aluOp = aluAdd;
                    {funct7Alt, funct3Add}: fields.aluOp = aluSub;
                    {funct7Base, funct3And}: fields.aluOp = aluAnd;
                    {funct7Base, funct3Or}: fields.aluOp = aluOr;
                    {funct7Base, funct3Slt}: fields.aluOp = aluSlt;
                    default: supported = 1'b0;
                endcase
            end
            OP_IMM: begin
                supported = (funct3 == funct3Add);
                fields.regWrite = 1'b1;
                fields.useImm = 1'b1;
                fields.rs2 = '0;
            end
            LOAD: begin
                supported = (funct3 == funct3Word);
                fields.regWrite = 1'b1;
                fields.memRead = 1'b1;
                fields.useImm = 1'b1;
                fields.rs2 = '0;
            end
            STORE: begin
                supported = (funct3 == funct3Word);
                fields.memWrite = 1'b1;
                fields.useImm = 1'b1;
                fields.rd = '0;
                immKind = immS;
            end
            BRANCH: begin
                // Only BEQ is decoded here
                supported = (funct3 == funct3Add);
                fields.branch = 1'b1;
                fields.rd = '0;
                immKind = immB;
            end
            JAL: begin
                supported = 1'b1;
                fields.regWrite = 1'b1;
                fields.jump = 1'b1;
                fields.rs1 = '0;
                fields.rs2 = '0;
                immKind = immJ;
            end
            default: supported = 1'b0;
        endcase

        fields.imm = immediate(instr, immKind);
        fields.valid = supported;

        // Anything outside the subset travels on as a bubble
        if (!supported) begin
            fields = '0;
        end
    end

endmodule

/* source/executeUnit.sv */
`timescale 1ns/1ns

module executeUnit
    import isaPkg::*;
    import pipePkg::*;
(
    input executeStageT stage,
    input forwardSelT forwardA,
    input forwardSelT forwardB,
    input wordT memoryResult,
    input wordT writebackResult,
    output wordT result,
    output wordT storeData,
    output wordT target,
    output logic takenBranch,
    output logic jump
);

    wordT operandA;
    wordT operandB;
    wordT aluB;
    wordT aluResult;

    // Replace a stale register value with a younger result still in flight
    function automatic wordT pickOperand(forwardSelT sel, wordT regValue);
        case (sel)
            forwardMemory: return memoryResult;
            forwardWriteback: return writebackResult;
            default: return regValue;
        endcase
    endfunction

    assign operandA = pickOperand(forwardA, stage.rs1Value);
    assign operandB = pickOperand(forwardB, stage.rs2Value);

    // Loads, stores and ADDI take the immediate as second operand
    assign aluB = stage.useImm ? stage.imm : operandB;

    always_comb begin
        case (stage.aluOp)
            aluSub: aluResult = operandA - aluB;
            aluAnd: aluResult = operandA & aluB;
            aluOr: aluResult = operandA | aluB;
            aluSlt: aluResult = ($signed(operandA) < $signed(aluB)) ? wordT'(1) : '0;
            default: aluResult = operandA + aluB;
        endcase
    end

    // Store data must see forwarding too, since the value may still be in flight
    assign storeData = operandB;

    // BEQ and JAL both jump relative to their own pc
    assign target = stage.pc + stage.imm;
    assign takenBranch = stage.branch && (operandA == operandB);
    assign jump = stage.jump;

    // JAL links the address of the next instruction
    assign result = stage.jump ? stage.pc + wordT'(4) : aluResult;

endmodule

/* source/hazardUnit.sv */
`timescale 1ns/1ns

module hazardUnit
    import isaPkg::*;
    import pipePkg::*;
(
    input regAddrT rs1Decode,
    input regAddrT rs2Decode,
    input regAddrT rs1Execute,
    input regAddrT rs2Execute,
    input regAddrT rdExecute,
    input regAddrT rdMemory,
    input regAddrT rdWriteback,
    input logic memReadExecute,
    input logic regWriteMemory,
    input logic regWriteWriteback,
    input logic takenBranch,
    input logic jump,
    input logic missStall,
    output forwardSelT forwardA,
    output forwardSelT forwardB,
    output logic stall,
    output logic flushDecode,
    output logic flushExecute,
    output logic freeze
);

    logic redirect;
    logic loadUse;

    // The youngest producer wins, so memory is checked before writeback
    // x0 is never forwarded because its value is always zero
    function automatic forwardSelT pickSource(regAddrT rs);
        if (rs == '0) begin
            return forwardNone;
        end
        if (regWriteMemory && (rs == rdMemory)) begin
            return forwardMemory;
        end
        if (regWriteWriteback && (rs == rdWriteback)) begin
            return forwardWriteback;
        end
        return forwardNone;
    endfunction

    assign forwardA = pickSource(rs1Execute);
    assign forwardB = pickSource(rs2Execute);

    // A taken BEQ or a JAL in execute replaces the two younger instructions
    assign redirect = takenBranch || jump;

    // Load result is not ready until writeback, so a dependent decode must wait
    assign loadUse = memReadExecute && (rdExecute != '0)
                     && ((rdExecute == rs1Decode) || (rdExecute == rs2Decode));

    // A waiting data access holds every stage in place
    assign freeze = missStall;

    // Redirect beats the load-use stall and the freeze beats both
    assign stall = loadUse && !redirect && !freeze;
    assign flushDecode = redirect && !freeze;

    // The load-use bubble enters execute through the same clear
    assign flushExecute = (redirect || loadUse) && !freeze;

endmodule

/* source/isaPkg.sv */
`include "coreCfg.svh"

package isaPkg;

    // Basic machine word and register number
    typedef logic [`XLEN-1:0] wordT;
    typedef logic [`REG_AW-1:0] regAddrT;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcodeT;

    // Operations the execute stage ALU can perform
    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOpT;

    // Layout of the immediate bits inside an instruction word
    typedef enum logic [1:0] {
        immI,
        immS,
        immB,
        immJ
    } immKindT;

    // Function field values used by the decoder
    localparam logic [2:0] funct3Add  = 3'b000;
    localparam logic [2:0] funct3Slt  = 3'b010;
    localparam logic [2:0] funct3Or   = 3'b110;
    localparam logic [2:0] funct3And  = 3'b111;
    // LW and SW share this width code
    localparam logic [2:0] funct3Word = 3'b010;
    localparam logic [6:0] funct7Base = 7'b0000000;
    localparam logic [6:0] funct7Alt  = 7'b0100000;

endpackage

/* source/pipePkg.sv */
package pipePkg;

    import isaPkg::*;

    // Operand source chosen by the hazard unit for the execute stage
    typedef enum logic [1:0] {
        forwardNone      = 2'b00,
        forwardWriteback = 2'b01,
        forwardMemory    = 2'b10
    } forwardSelT;

    // Fetch to decode register
    typedef struct packed {
        logic valid;
        wordT pc;
        wordT instr;
    } decodeStageT;

    // Decode to execute register, the decoder fills all but the register values
    typedef struct packed {
        logic valid;
        wordT pc;
        regAddrT rs1;
        regAddrT rs2;
        regAddrT rd;
        wordT rs1Value;
        wordT rs2Value;
        wordT imm;
        aluOpT aluOp;
        logic useImm;
        logic regWrite;
        logic memRead;
        logic memWrite;
        logic branch;
        logic jump;
    } executeStageT;

    // Execute to memory register
    typedef struct packed {
        logic valid;
        wordT pc;
        regAddrT rd;
        wordT result;
        wordT storeData;
        logic regWrite;
        logic memRead;
        logic memWrite;
    } memoryStageT;

    // Memory to writeback register
    typedef struct packed {
        logic valid;
        wordT pc;
        regAddrT rd;
        wordT result;
        logic regWrite;
    } writebackStageT;

    // Word request toward data memory
    typedef struct packed {
        logic valid;
        logic write;
        wordT addr;
        wordT wdata;
    } memReqT;

    // One record per completed instruction
    typedef struct packed {
        logic valid;
        wordT pc;
        logic regWrite;
        regAddrT rd;
        wordT result;
    } retireT;

endpackage

/* source/pipeStage.sv */
`timescale 1ns/1ns

module pipeStage #(
    parameter type payloadT = logic
)(
    input logic clk,
    input logic rst,
    input logic enable,
    input logic clear,
    input payloadT d,
    output payloadT q
);

    // An all-zero payload has valid low and every flag low, which is a bubble
    // Clear only acts when the stage is enabled, so a frozen stage keeps its contents
    always_ff @(posedge clk) begin
        if (rst) begin
            q <= '0;
        end else if (enable) begin
            q <= clear ? payloadT'('0) : d;
        end
    end

endmodule

/* source/pipelineCore.sv */
`timescale 1ns/1ns
`include "coreCfg.svh"

module pipelineCore
    import isaPkg::*;
    import pipePkg::*;
(
    input logic clk,
    input logic rst,
    output wordT imemAddr,
    input wordT imemData,
    output memReqT dmemReq,
    input wordT dmemRdata,
    input logic dmemReady,
    output retireT retire
);

    wordT pc;
    wordT pcNext;
    decodeStageT decodeIn;
    decodeStageT decodeQ;
    executeStageT decodeFields;
    executeStageT executeIn;
    executeStageT executeQ;
    memoryStageT memoryIn;
    memoryStageT memoryQ;
    writebackStageT writebackIn;
    writebackStageT writebackQ;
    wordT regValueA;
    wordT regValueB;
    wordT exResult;
    wordT exStoreData;
    wordT exTarget;
    forwardSelT forwardA;
    forwardSelT forwardB;
    logic takenBranch;
    logic jump;
    logic stall;
    logic flushDecode;
    logic flushExecute;
    logic freeze;
    logic missStall;
    logic memAccess;
    logic frontEnable;
    logic backEnable;

    // Fetch and decode wait on a load-use stall, every stage waits on a miss
    assign frontEnable = !freeze && !stall;
    assign backEnable = !freeze;

    // A redirect from execute takes the place of the sequential pc
    assign pcNext = (takenBranch || jump) ? exTarget : pc + wordT'(4);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RESET_PC;
        end else if (frontEnable) begin
            pc <= pcNext;
        end
    end

    // Instruction memory answers in the same cycle
    assign imemAddr = pc;
    assign decodeIn = '{valid: 1'b1, pc: pc, instr: imemData};

    pipeStage #(.payloadT(decodeStageT)) decodeReg_i (
        .clk(clk),
        .rst(rst),
        .enable(frontEnable),
        .clear(flushDecode),
        .d(decodeIn),
        .q(decodeQ)
    );

    decoder decoder_i (
        .pc(decodeQ.pc),
        .instr(decodeQ.instr),
        .fields(decodeFields)
    );

    regFile regFile_i (
        .clk(clk),
        .rst(rst),
        .readAddrA(decodeFields.rs1),
        .readAddrB(decodeFields.rs2),
        .readDataA(regValueA),
        .readDataB(regValueB),
        .writeEnable(writebackQ.regWrite),
        .writeAddr(writebackQ.rd),
        .writeData(writebackQ.result)
    );

    // Register values join the decoded controls on the way into execute
    always_comb begin
        executeIn = decodeFields;
        executeIn.valid = decodeFields.valid && decodeQ.valid;
        executeIn.rs1Value = regValueA;
        executeIn.rs2Value = regValueB;
    end

    pipeStage #(.payloadT(executeStageT)) executeReg_i (
        .clk(clk),
        .rst(rst),
        .enable(backEnable),
        .clear(flushExecute),
        .d(executeIn),
        .q(executeQ)
    );

    executeUnit executeUnit_i (
        .stage(executeQ),
        .forwardA(forwardA),
        .forwardB(forwardB),
        .memoryResult(memoryQ.result),
        .writebackResult(writebackQ.result),
        .result(exResult),
        .storeData(exStoreData),
        .target(exTarget),
        .takenBranch(takenBranch),
        .jump(jump)
    );

    hazardUnit hazardUnit_i (
        .rs1Decode(decodeFields.rs1),
        .rs2Decode(decodeFields.rs2),
        .rs1Execute(executeQ.rs1),
        .rs2Execute(executeQ.rs2),
        .rdExecute(executeQ.rd),
        .rdMemory(memoryQ.rd),
        .rdWriteback(writebackQ.rd),
        .memReadExecute(executeQ.memRead),
        .regWriteMemory(memoryQ.regWrite),
        .regWriteWriteback(writebackQ.regWrite),
        .takenBranch(takenBranch),
        .jump(jump),
        .missStall(missStall),
        .forwardA(forwardA),
        .forwardB(forwardB),
        .stall(stall),
        .flushDecode(flushDecode),
        .flushExecute(flushExecute),
        .freeze(freeze)
    );

    always_comb begin
        memoryIn.valid = executeQ.valid;
        memoryIn.pc = executeQ.pc;
        memoryIn.rd = executeQ.rd;
        memoryIn.result = exResult;
        memoryIn.storeData = exStoreData;
        memoryIn.regWrite = executeQ.regWrite;
        memoryIn.memRead = executeQ.memRead;
        memoryIn.memWrite = executeQ.memWrite;
    end

    pipeStage #(.payloadT(memoryStageT)) memoryReg_i (
        .clk(clk),
        .rst(rst),
        .enable(backEnable),
        .clear(1'b0),
        .d(memoryIn),
        .q(memoryQ)
    );

    // The frozen memory register keeps the request steady until ready comes back
    assign memAccess = memoryQ.memRead || memoryQ.memWrite;
    assign missStall = memAccess && !dmemReady;
    assign dmemReq = '{
        valid: memAccess,
        write: memoryQ.memWrite,
        addr: memoryQ.result,
        wdata: memoryQ.storeData
    };

    // Load data is only sampled in the cycle ready is high
    always_comb begin
        writebackIn.valid = memoryQ.valid;
        writebackIn.pc = memoryQ.pc;
        writebackIn.rd = memoryQ.rd;
        writebackIn.result = memoryQ.memRead ? dmemRdata : memoryQ.result;
        writebackIn.regWrite = memoryQ.regWrite;
    end

    pipeStage #(.payloadT(writebackStageT)) writebackReg_i (
        .clk(clk),
        .rst(rst),
        .enable(backEnable),
        .clear(1'b0),
        .d(writebackIn),
        .q(writebackQ)
    );

    // A held writeback stage reports its instruction once, in the cycle the freeze lifts
    assign retire = '{
        valid: writebackQ.valid && !freeze,
        pc: writebackQ.pc,
        regWrite: writebackQ.regWrite,
        rd: writebackQ.rd,
        result: writebackQ.result
    };

endmodule

/* source/regFile.sv */
`timescale 1ns/1ns

module regFile
    import isaPkg::*;
(
    input logic clk,
    input logic rst,
    input regAddrT readAddrA,
    input regAddrT readAddrB,
    output wordT readDataA,
    output wordT readDataB,
    input logic writeEnable,
    input regAddrT writeAddr,
    input wordT writeData
);

    // x0 has no storage behind it
    wordT regs [1:31];

    // Writes are ignored while the core is in reset
    always_ff @(posedge clk) begin
        if (!rst && writeEnable && (writeAddr != '0)) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Writeback and decode share a cycle, so a same-register write passes straight through
    function automatic wordT readPort(regAddrT addr);
        if (addr == '0) begin
            return '0;
        end
        if (writeEnable && (writeAddr == addr)) begin
            return writeData;
        end
        return regs[addr];
    endfunction

    assign readDataA = readPort(readAddrA);
    assign readDataB = readPort(readAddrB);

endmodule

/* src.f */
+incdir+source
source/isaPkg.sv
source/pipePkg.sv
source/hazardUnit.sv
source/regFile.sv
source/decoder.sv
source/pipeStage.sv
source/executeUnit.sv
source/pipelineCore.sv
sim/coreChecker.sv
sim/coreTb.sv
